//--- list.f
mdu_pkg.sv
mdu_ctrl.sv
operand_prep.sv
shift_divider.sv
shift_multiplier.sv
result_fixup.sv
mdu_top.sv
mdu_tb.sv

//--- mdu_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module mdu_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic flush,
	output logic busy,
	output logic load,
	output logic step,
	output logic finish,
	output logic done
);
	import mdu_pkg::*;

	mdu_state_t state;
	logic [cnt_width-1:0] cnt;
	logic accept;

	// A start is taken only from idle, and a flush in the same cycle cancels it
	assign accept = (state == st_idle) && start && !flush;

	//////////////////////////////////////////////////
	// Sequencing
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			cnt <= '0;
			load <= 1'b0;
		end else if (flush) begin
			state <= st_idle; // Abandon whatever is in flight
			cnt <= '0;
			load <= 1'b0;
		end else begin
			load <= accept;
			case (state)
				st_idle: begin
					if (accept) begin
						state <= st_run;
						cnt <= cnt_width'(iter_count);
					end
				end
				st_run: begin
					if (step) begin
						cnt <= cnt - 1'b1;
					end
					if (finish) begin
						state <= st_done;
					end
				end
				st_done: begin
					state <= st_idle; // Done lasts exactly one cycle
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs
	//////////////////////////////////////////////////

	// The load cycle sits inside st_run but runs no iteration
	assign step = (state == st_run) && !load && (cnt != '0);

	// Keeps the result register untouched when a flush arrives at the last moment
	assign finish = (state == st_run) && !load && (cnt == '0) && !flush;

	assign done = (state == st_done);
	assign busy = (state != st_idle);

endmodule

`default_nettype wire

//--- mdu_pkg.sv
`default_nettype none

package mdu_pkg;

	//////////////////////////////////////////////////
	// Widths and iteration count
	//////////////////////////////////////////////////

	localparam int xlen = 64; // One machine word
	localparam int iter_count = xlen; // One quotient or product bit per iteration

	// Counter holds iter_count itself, so one bit more than log2(xlen)
	localparam int cnt_width = 7;

	//////////////////////////////////////////////////
	// Operations and controller states
	//////////////////////////////////////////////////

	// Multiply group first, then the divide group, so bit 2 marks a division
	typedef enum logic [2:0] {
		op_mul    = 3'd0, // Low half of the product
		op_mulh   = 3'd1, // High half, both operands signed
		op_mulhsu = 3'd2, // High half, op1 signed and op2 unsigned
		op_mulhu  = 3'd3, // High half, both operands unsigned
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} mdu_op_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run  = 2'd1, // Load cycle followed by the iterations
		st_done = 2'd2
	} mdu_state_t;

endpackage

`default_nettype wire

//--- mdu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mdu_tb;
	import mdu_pkg::*;

	localparam int n_ops = 2 * 4 * 2 * 16 + 200 + 3;
	localparam int watchdog_cycles = n_ops * 70 + 1000;

	logic clk;
	logic reset;
	logic start;
	logic flush;
	logic word;
	mdu_op_t op;
	logic [xlen-1:0] op1;
	logic [xlen-1:0] op2;
	logic busy;
	logic done;
	logic [xlen-1:0] result;

	logic [xlen-1:0] expected;
	logic expect_done; // High while an operation may still deliver its done
	logic started;
	int latency;
	int errors;
	int ops_run;
	int err_mark;
	int ops_mark;
	logic [31:0] rng_state;

	mdu_top uut (.clk(clk), .reset(reset), .start(start), .flush(flush), .word(word),
		.op(op), .op1(op1), .op2(op2), .busy(busy), .done(done), .result(result));

	always #5 clk = ~clk;

	// Edges counted from the edge that accepted the last start
	always @(posedge clk) begin
		if (reset || (start && !busy && !flush)) begin
			latency <= 0;
		end else if (latency < 1000) begin
			latency <= latency + 1;
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	reset_state: assert property (@(posedge clk) disable iff (reset)
		!started |-> (!busy && !done && result == '0))
		else begin
			errors++;
			$display("Mismatch at %0t: unit not idle with a zero result after reset", $time);
		end

	done_latency: assert property (@(posedge clk) disable iff (reset)
		done |-> (latency == iter_count + 2))
		else begin
			errors++;
			$display("Mismatch at %0t: done came %0d edges after start", $time,
				$sampled(latency));
		end

	done_result: assert property (@(posedge clk) disable iff (reset)
		done |-> (result == expected))
		else begin
			errors++;
			$display("Mismatch at %0t: result %h, expected %h", $time, result, expected);
		end

	done_wanted: assert property (@(posedge clk) disable iff (reset)
		done |-> expect_done)
		else begin
			errors++;
			$display("Unexpected done pulse at %0t with no operation pending", $time);
		end

	done_single: assert property (@(posedge clk) disable iff (reset)
		done |=> (!done && !busy))
		else begin
			errors++;
			$display("Mismatch at %0t: done or busy still high after the done cycle", $time);
		end

	flush_idle: assert property (@(posedge clk) disable iff (reset)
		flush |=> !busy)
		else begin
			errors++;
			$display("Mismatch at %0t: busy still high one edge after flush", $time);
		end

	//////////////////////////////////////////////////
	// Reference model and stimulus helpers
	//////////////////////////////////////////////////

	function automatic logic [xlen-1:0] model_result(input mdu_op_t o, input logic w,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		logic s1;
		logic s2;
		logic [xlen-1:0] x;
		logic [xlen-1:0] y;
		logic signed [2*xlen-1:0] xw;
		logic signed [2*xlen-1:0] yw;
		logic [2*xlen-1:0] wide;
		logic [xlen-1:0] r;
		s1 = (o == op_mul) || (o == op_mulh) || (o == op_mulhsu) || (o == op_div) || (o == op_rem);
		s2 = (o == op_mul) || (o == op_mulh) || (o == op_div) || (o == op_rem);
		x = a;
		y = b;
		if (w) begin
			x = s1 ? {{32{a[31]}}, a[31:0]} : {32'b0, a[31:0]};
			y = s2 ? {{32{b[31]}}, b[31:0]} : {32'b0, b[31:0]};
		end
		xw = s1 ? {{xlen{x[xlen-1]}}, x} : {{xlen{1'b0}}, x};
		yw = s2 ? {{xlen{y[xlen-1]}}, y} : {{xlen{1'b0}}, y};
		case (o)
			op_mul, op_mulh, op_mulhsu, op_mulhu: begin
				wide = xw * yw;
				r = (o == op_mul) ? wide[xlen-1:0] : wide[2*xlen-1:xlen];
			end
			default: begin
				if (y == '0) begin
					r = (o == op_div || o == op_divu) ? '1 : x;
				end else if (o == op_div || o == op_divu) begin
					wide = xw / yw; // Wide enough that minimum over minus one cannot overflow
					r = wide[xlen-1:0];
				end else begin
					wide = xw % yw;
					r = wide[xlen-1:0];
				end
			end
		endcase
		if (w) begin
			r = {{32{r[31]}}, r[31:0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] rand32();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Word corners carry junk in the upper half to exercise the extension
	function automatic logic [xlen-1:0] corner(input logic w, input int idx);
		case (idx)
			0: return w ? 64'h1234_5678_8000_0000 : 64'h8000_0000_0000_0000;
			1: return '1;
			2: return w ? 64'hffff_0000_0000_0000 : 64'h0;
			default: return w ? 64'h0000_00ab_7fff_ffff : 64'h7fff_ffff_ffff_ffff;
		endcase
	endfunction

	task automatic next_edge;
		@(posedge clk);
		#1;
	endtask

	task automatic issue_start(input mdu_op_t o, input logic w,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		op = o;
		word = w;
		op1 = a;
		op2 = b;
		expected = model_result(o, w, a, b);
		expect_done = 1'b1;
		started = 1'b1;
		start = 1'b1;
		next_edge();
		start = 1'b0;
		ops_run++;
	endtask

	task automatic wait_for_done;
		int waited;
		waited = 0;
		while (!done && waited < iter_count + 16) begin
			next_edge();
			waited++;
		end
		if (!done) begin
			errors++;
			$display("No done pulse by %0t, the operation never finished", $time);
		end
		next_edge(); // Done is checked at this edge before the flag drops
		expect_done = 1'b0;
	endtask

	task automatic run_op(input mdu_op_t o, input logic w,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		issue_start(o, w, a, b);
		wait_for_done();
	endtask

	task automatic sweep_ops(input int first_op);
		int w;
		int o;
		int i;
		int j;
		for (w = 0; w < 2; w++) begin
			for (o = first_op; o < first_op + 4; o++) begin
				for (i = 0; i < 4; i++) begin
					for (j = 0; j < 4; j++) begin
						run_op(mdu_op_t'(o), w[0], corner(w[0], i), corner(w[0], j));
					end
				end
			end
		end
	endtask

	task automatic random_ops(input int count);
		logic [31:0] r;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		int n;
		for (n = 0; n < count; n++) begin
			r = rand32();
			a[63:32] = rand32();
			a[31:0] = rand32();
			b[63:32] = rand32();
			b[31:0] = rand32();
			if (r[5:3] == 3'd0) begin
				b = b & 64'hff; // Small divisors give long quotients
			end
			if (r[8:6] == 3'd0) begin
				b = '0;
			end
			run_op(mdu_op_t'(r[2:0]), r[9], a, b);
		end
	endtask

	task automatic start_while_busy;
		issue_start(op_divu, 1'b0, 64'hffff_ffff_ffff_fff1, 64'd7);
		repeat (20) next_edge();
		op = op_mul;
		op1 = 64'd3;
		op2 = 64'd5;
		start = 1'b1;
		next_edge();
		start = 1'b0;
		wait_for_done();
		repeat (iter_count + 6) next_edge(); // A second done would trip done_wanted
	endtask

	task automatic flush_mid_op;
		issue_start(op_rem, 1'b0, 64'h8000_0000_0000_0000, 64'd3);
		repeat (30) next_edge();
		expect_done = 1'b0;
		flush = 1'b1;
		next_edge();
		flush = 1'b0;
		repeat (iter_count + 6) next_edge();
		run_op(op_mulhsu, 1'b0, 64'hffff_ffff_ffff_fffe, 64'h8000_0000_0000_0001);
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d operations, %0d errors", name, ops_run - ops_mark,
			errors - err_mark);
		err_mark = errors;
		ops_mark = ops_run;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		flush = 1'b0;
		word = 1'b0;
		op = op_mul;
		op1 = '0;
		op2 = '0;
		expected = '0;
		expect_done = 1'b0;
		started = 1'b0;
		errors = 0;
		ops_run = 0;
		err_mark = 0;
		ops_mark = 0;
		rng_state = 32'h2ca;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (4) next_edge();
		report_test("reset");
		sweep_ops(0);
		report_test("multiply");
		sweep_ops(4);
		report_test("divide");
		random_ops(200);
		report_test("random");
		start_while_busy();
		report_test("start_while_busy");
		flush_mid_op();
		report_test("flush");
		$display("%0d operations, %0d errors in total", ops_run, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdog_cycles * 10);
		$display("Watchdog timeout at %0t, the run did not finish in time", $time);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- mdu_top.sv
`timescale 1ns/10ps
`default_nettype none

module mdu_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    start,
	input  logic                    flush,
	input  logic                    word,
	input  mdu_pkg::mdu_op_t        op,
	input  logic [mdu_pkg::xlen-1:0] op1,
	input  logic [mdu_pkg::xlen-1:0] op2,
	output logic                    busy,
	output logic                    done,
	output logic [mdu_pkg::xlen-1:0] result
);
	import mdu_pkg::*;

	logic load;
	logic step;
	logic finish;
	logic [xlen-1:0] mag1;
	logic [xlen-1:0] mag2;
	logic [xlen-1:0] op1_ext;
	logic neg1;
	logic neg2;
	logic div_sel;
	logic div_zero;
	logic word_q;
	mdu_op_t op_q;
	logic [xlen-1:0] quo;
	logic [xlen-1:0] rem;
	logic [2*xlen-1:0] prod;

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////

	mdu_ctrl ctrl (.clk(clk), .reset(reset), .start(start), .flush(flush), .busy(busy),
		.load(load), .step(step), .finish(finish), .done(done));

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	operand_prep prep (.clk(clk), .reset(reset), .load(load), .op(op), .word(word),
		.op1(op1), .op2(op2), .mag1(mag1), .mag2(mag2), .op1_ext(op1_ext),
		.neg1(neg1), .neg2(neg2), .div_sel(div_sel), .div_zero(div_zero),
		.word_q(word_q), .op_q(op_q));

	// Both arithmetic blocks see every step, div_sel decides which one moves
	shift_divider divider (.clk(clk), .reset(reset), .load(load), .step(step),
		.div_sel(div_sel), .mag1(mag1), .mag2(mag2), .quo(quo), .rem(rem));

	shift_multiplier multiplier (.clk(clk), .reset(reset), .load(load), .step(step),
		.div_sel(div_sel), .mag1(mag1), .mag2(mag2), .prod(prod));

	result_fixup fixup (.clk(clk), .reset(reset), .finish(finish), .op_q(op_q),
		.word_q(word_q), .neg1(neg1), .neg2(neg2), .div_zero(div_zero),
		.op1_ext(op1_ext), .quo(quo), .rem(rem), .prod(prod), .result(result));

endmodule

`default_nettype wire

//--- operand_prep.sv
`timescale 1ns/10ps
`default_nettype none

module operand_prep (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load,
	input  mdu_pkg::mdu_op_t        op,
	input  logic                    word,
	input  logic [mdu_pkg::xlen-1:0] op1,
	input  logic [mdu_pkg::xlen-1:0] op2,
	output logic [mdu_pkg::xlen-1:0] mag1,
	output logic [mdu_pkg::xlen-1:0] mag2,
	output logic [mdu_pkg::xlen-1:0] op1_ext,
	output logic                    neg1,
	output logic                    neg2,
	output logic                    div_sel,
	output logic                    div_zero,
	output logic                    word_q,
	output mdu_pkg::mdu_op_t        op_q
);
	import mdu_pkg::*;

	logic sign1;
	logic sign2;
	logic is_div;
	logic [xlen-1:0] ext1;
	logic [xlen-1:0] ext2;
	logic [xlen-1:0] abs1;
	logic [xlen-1:0] abs2;

	// MUL is treated as signed, the low half comes out the same either way
	always_comb begin
		sign1 = 1'b0;
		sign2 = 1'b0;
		is_div = 1'b0;
		case (op)
			op_mul, op_mulh: begin
				sign1 = 1'b1;
				sign2 = 1'b1;
			end
			op_mulhsu: sign1 = 1'b1;
			op_div, op_rem: begin
				sign1 = 1'b1;
				sign2 = 1'b1;
				is_div = 1'b1;
			end
			op_divu, op_remu: is_div = 1'b1;
			default: is_div = 1'b0;
		endcase
	end

	// Word operands are sign- or zero-extended from bit 31 by signedness
	assign ext1 = word ? {{(xlen-32){sign1 & op1[31]}}, op1[31:0]} : op1;
	assign ext2 = word ? {{(xlen-32){sign2 & op2[31]}}, op2[31:0]} : op2;

	assign abs1 = (sign1 && ext1[xlen-1]) ? -ext1 : ext1;
	assign abs2 = (sign2 && ext2[xlen-1]) ? -ext2 : ext2;

	always_ff @(posedge clk) begin
		if (reset) begin
			neg1 <= 1'b0;
			neg2 <= 1'b0;
			div_sel <= 1'b0;
			div_zero <= 1'b0;
			word_q <= 1'b0;
			op_q <= op_mul;
		end else if (load) begin
			neg1 <= sign1 & ext1[xlen-1];
			neg2 <= sign2 & ext2[xlen-1];
			div_sel <= is_div;
			div_zero <= (ext2 == '0);
			word_q <= word;
			op_q <= op;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			mag1 <= abs1;
			mag2 <= abs2;
			op1_ext <= ext1; // Becomes the remainder on a divide by zero
		end
	end

endmodule

`default_nettype wire

//--- result_fixup.sv
`timescale 1ns/10ps
`default_nettype none

module result_fixup (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      finish,
	input  mdu_pkg::mdu_op_t          op_q,
	input  logic                      word_q,
	input  logic                      neg1,
	input  logic                      neg2,
	input  logic                      div_zero,
	input  logic [mdu_pkg::xlen-1:0]   op1_ext,
	input  logic [mdu_pkg::xlen-1:0]   quo,
	input  logic [mdu_pkg::xlen-1:0]   rem,
	input  logic [2*mdu_pkg::xlen-1:0] prod,
	output logic [mdu_pkg::xlen-1:0]   result
);
	import mdu_pkg::*;

	logic [2*xlen-1:0] prod_s;
	logic [xlen-1:0] quo_s;
	logic [xlen-1:0] rem_s;
	logic [xlen-1:0] sel;
	logic [xlen-1:0] sel_ext;

	assign prod_s = (neg1 ^ neg2) ? -prod : prod;

	// Divide by zero bypasses the magnitude result
	assign quo_s = div_zero ? '1 : ((neg1 ^ neg2) ? -quo : quo);
	assign rem_s = div_zero ? op1_ext : (neg1 ? -rem : rem); // Remainder follows the dividend

	always_comb begin
		case (op_q)
			op_mul: sel = prod_s[xlen-1:0];
			op_mulh, op_mulhsu, op_mulhu: sel = prod_s[2*xlen-1:xlen];
			op_div, op_divu: sel = quo_s;
			default: sel = rem_s;
		endcase
	end

	assign sel_ext = word_q ? {{(xlen-32){sel[31]}}, sel[31:0]} : sel;

	// Held until the next finish
	always_ff @(posedge clk) begin
		if (reset) begin
			result <= '0;
		end else if (finish) begin
			result <= sel_ext;
		end
	end

endmodule

`default_nettype wire

//--- shift_divider.sv
`timescale 1ns/10ps
`default_nettype none

module shift_divider (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    load,
	input  logic                    step,
	input  logic                    div_sel,
	input  logic [mdu_pkg::xlen-1:0] mag1,
	input  logic [mdu_pkg::xlen-1:0] mag2,
	output logic [mdu_pkg::xlen-1:0] quo,
	output logic [mdu_pkg::xlen-1:0] rem
);
	import mdu_pkg::*;

	logic first_step;
	logic [2*xlen-1:0] part_q; // Remainder on top, unused dividend bits below
	logic [xlen-1:0] quo_q;
	logic [2*xlen-1:0] part_cur;
	logic [xlen:0] diff;
	logic diff_neg;

	// Magnitudes are registered on the load edge, so the first step reads them directly
	always_ff @(posedge clk) begin
		if (reset) begin
			first_step <= 1'b0;
		end else if (load) begin
			first_step <= 1'b1;
		end else if (step) begin
			first_step <= 1'b0;
		end
	end

	assign part_cur = first_step ? {{xlen{1'b0}}, mag1} : part_q;

	//////////////////////////////////////////////////
	// One restoring iteration
	//////////////////////////////////////////////////

	// Trial subtract from the remainder shifted left by one dividend bit
	assign diff = part_cur[2*xlen-1:xlen-1] - {1'b0, mag2};
	assign diff_neg = diff[xlen];

	always_ff @(posedge clk) begin
		if (step && div_sel) begin
			if (diff_neg) begin
				part_q <= {part_cur[2*xlen-2:0], 1'b0}; // Restore by keeping the shift only
			end else begin
				part_q <= {diff[xlen-1:0], part_cur[xlen-2:0], 1'b0};
			end
			quo_q <= {quo_q[xlen-2:0], !diff_neg};
		end
	end

	assign quo = quo_q;
	assign rem = part_q[2*xlen-1:xlen];

endmodule

`default_nettype wire

//--- shift_multiplier.sv
`timescale 1ns/10ps
`default_nettype none

module shift_multiplier (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      load,
	input  logic                      step,
	input  logic                      div_sel,
	input  logic [mdu_pkg::xlen-1:0]   mag1,
	input  logic [mdu_pkg::xlen-1:0]   mag2,
	output logic [2*mdu_pkg::xlen-1:0] prod
);
	import mdu_pkg::*;

	logic first_step;
	logic [xlen-1:0] acc_q;
	logic [xlen-1:0] mplr_q; // Low product bits fill in from the top as it drains
	logic [xlen-1:0] acc_cur;
	logic [xlen-1:0] mplr_cur;
	logic [xlen-1:0] addend;
	logic [xlen:0] sum;

	always_ff @(posedge clk) begin
		if (reset) begin
			first_step <= 1'b0;
		end else if (load) begin
			first_step <= 1'b1;
		end else if (step) begin
			first_step <= 1'b0;
		end
	end

	// First iteration starts from a clear accumulator and the fresh multiplier
	assign acc_cur = first_step ? '0 : acc_q;
	assign mplr_cur = first_step ? mag2 : mplr_q;

	//////////////////////////////////////////////////
	// Add and shift
	//////////////////////////////////////////////////

	assign addend = mplr_cur[0] ? mag1 : '0;
	assign sum = {1'b0, acc_cur} + {1'b0, addend}; // Carry kept for the shift

	always_ff @(posedge clk) begin
		if (step && !div_sel) begin
			acc_q <= sum[xlen:1];
			mplr_q <= {sum[0], mplr_cur[xlen-1:1]};
		end
	end

	assign prod = {acc_q, mplr_q};

endmodule

`default_nettype wire
